/* fletcher_params.svh */
`ifndef FLETCHER_PARAMS_SVH
`define FLETCHER_PARAMS_SVH

`define FL_WORD_W 16
`define FL_CSUM_W 32
`define FL_LEN_W 16
`define FL_ADDR_W 3

`define FL_REG_CTRL 3'd0
`define FL_REG_EXPECT 3'd1
`define FL_REG_LAST 3'd2
`define FL_REG_LEN 3'd3
`define FL_REG_FRAMES 3'd4
`define FL_REG_ERRORS 3'd5

`endif

/* fletcherPkg.sv */
`default_nettype none

`include "fletcher_params.svh"

package fletcherPkg;

    // One word of the input stream
    typedef logic [`FL_WORD_W-1:0] word_t;

    // A running sum, kept modulo 65535 so 16'hFFFF also stands for zero
    typedef logic [`FL_WORD_W-1:0] halfSum_t;

    typedef struct packed {
        halfSum_t sumB; // Upper half of the checksum
        halfSum_t sumA; // Lower half of the checksum
    } csum_t;

    typedef logic [`FL_LEN_W-1:0] frameLen_t;

    typedef logic [`FL_ADDR_W-1:0] regAddr_t;

    typedef logic [`FL_CSUM_W-1:0] regData_t;

endpackage

`default_nettype wire

/* fletcherIfs.sv */
`timescale 1ns/1ps
`default_nettype none

// Finished frame result from the engine, valid only while done is high
interface csumResultIf
    import fletcherPkg::*;
();
    logic      done;
    csum_t     checksum;
    frameLen_t length;

    modport engine (
        output done,
        output checksum,
        output length
    );

    modport check (
        input done,
        input checksum,
        input length
    );
endinterface

// Settings from the register block and per-frame status going back to it
interface csumStatusIf
    import fletcherPkg::*;
();
    logic      compareEn;
    csum_t     expected;
    logic      frameDone;
    logic      mismatch;
    csum_t     lastChecksum;
    frameLen_t lastLength;

    modport regs (
        output compareEn,
        output expected,
        input  frameDone,
        input  mismatch,
        input  lastChecksum,
        input  lastLength
    );

    modport check (
        input  compareEn,
        input  expected,
        output frameDone,
        output mismatch,
        output lastChecksum,
        output lastLength
    );
endinterface

`default_nettype wire

/* fletcherEngine.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fletcher_params.svh"

module fletcherEngine
    import fletcherPkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  wordValid,
    input  wire word_t wordData,
    input  wire logic  wordLast,
    csumResultIf.engine res
);

    halfSum_t  sumA;
    halfSum_t  sumB;
    frameLen_t lenCnt;
    halfSum_t  nextA;
    halfSum_t  nextB;
    logic      frameEnd;

    // Ones' complement add, the carry out wraps back into bit 0
    function automatic halfSum_t eacAdd(input halfSum_t a, input halfSum_t b);
        logic [`FL_WORD_W:0] full;
        full = {1'b0, a} + {1'b0, b};
        return full[`FL_WORD_W-1:0] + halfSum_t'(full[`FL_WORD_W]);
    endfunction

    // All ones is the second encoding of zero and is reported as zero
    function automatic halfSum_t reduce(input halfSum_t s);
        return (s == '1) ? '0 : s;
    endfunction

    assign frameEnd = wordValid && wordLast;

    // B picks up the already updated A, as the checksum rule requires
    always_comb begin
        nextA = eacAdd(sumA, wordData);
        nextB = eacAdd(sumB, nextA);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sumA   <= '0;
            sumB   <= '0;
            lenCnt <= '0;
        end else if (wordValid) begin
            if (wordLast) begin
                sumA   <= '0; // Next frame may start in the very next cycle
                sumB   <= '0;
                lenCnt <= '0;
            end else begin
                sumA   <= nextA;
                sumB   <= nextB;
                lenCnt <= lenCnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res.done <= 1'b0;
        end else begin
            res.done <= frameEnd; // One-cycle pulse after the last word
        end
    end

    // Result fields are only looked at while done is high
    always_ff @(posedge clk) begin
        if (frameEnd) begin
            res.checksum.sumA <= reduce(nextA);
            res.checksum.sumB <= reduce(nextB);
            res.length        <= lenCnt + 1'b1; // Count includes the last word
        end
    end

endmodule

`default_nettype wire

/* frameCheck.sv */
`timescale 1ns/1ps
`default_nettype none

module frameCheck
    import fletcherPkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst,
    csumResultIf.check  res,
    csumStatusIf.check  status,
    output logic        csumValid,
    output csum_t       csum,
    output logic        csumMatch
);

    frameLen_t lenReg;
    logic      matchNow;

    // With comparison off every frame counts as a match
    assign matchNow = !status.compareEn || (res.checksum == status.expected);

    always_ff @(posedge clk) begin
        if (rst) begin
            csumValid <= 1'b0;
            csumMatch <= 1'b0;
        end else begin
            csumValid <= res.done;
            csumMatch <= res.done && matchNow; // Only meaningful alongside csumValid
        end
    end

    always_ff @(posedge clk) begin
        if (res.done) begin
            csum   <= res.checksum;
            lenReg <= res.length;
        end
    end

    // Status to the register block follows the top-level result pulse
    assign status.frameDone    = csumValid;
    assign status.mismatch     = csumValid && !csumMatch;
    assign status.lastChecksum = csum;
    assign status.lastLength   = lenReg;

endmodule

`default_nettype wire

/* csumRegs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fletcher_params.svh"

module csumRegs
    import fletcherPkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     regWrite,
    input  wire logic     regRead,
    input  wire regAddr_t regAddr,
    input  wire regData_t regWriteData,
    output regData_t      regReadData,
    output logic          regReadValid,
    csumStatusIf.regs     status
);

    csum_t     lastChecksum;
    frameLen_t lastLength;
    regData_t  frameCount;
    regData_t  errorCount;
    logic      ctrlWrite;
    logic      clearCounters;
    regData_t  readMux;

    assign ctrlWrite     = regWrite && (regAddr == `FL_REG_CTRL);
    assign clearCounters = ctrlWrite && regWriteData[1]; // Bit 1 is a strobe, never stored

    always_ff @(posedge clk) begin
        if (rst) begin
            status.compareEn <= 1'b0;
            status.expected  <= '0;
        end else begin
            if (ctrlWrite) begin
                status.compareEn <= regWriteData[0];
            end
            if (regWrite && (regAddr == `FL_REG_EXPECT)) begin
                status.expected <= csum_t'(regWriteData);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            frameCount   <= '0;
            errorCount   <= '0;
            lastChecksum <= '0;
            lastLength   <= '0;
        end else begin
            if (clearCounters) begin
                frameCount <= '0; // A clear wins over a frame finishing in the same cycle
                errorCount <= '0;
            end else if (status.frameDone) begin
                if (frameCount != '1) begin
                    frameCount <= frameCount + 1'b1;
                end
                if (status.mismatch && (errorCount != '1)) begin
                    errorCount <= errorCount + 1'b1;
                end
            end
            if (status.frameDone) begin
                lastChecksum <= status.lastChecksum;
                lastLength   <= status.lastLength;
            end
        end
    end

    always_comb begin
        case (regAddr)
            `FL_REG_CTRL:   readMux = regData_t'(status.compareEn);
            `FL_REG_EXPECT: readMux = regData_t'(status.expected);
            `FL_REG_LAST:   readMux = regData_t'(lastChecksum);
            `FL_REG_LEN:    readMux = regData_t'(lastLength);
            `FL_REG_FRAMES: readMux = frameCount;
            `FL_REG_ERRORS: readMux = errorCount;
            default:        readMux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            regReadValid <= 1'b0;
        end else begin
            regReadValid <= regRead;
        end
    end

    always_ff @(posedge clk) begin
        if (regRead) begin
            regReadData <= readMux;
        end
    end

endmodule

`default_nettype wire

/* fletcherChecker.sv */
`timescale 1ns/1ps
`default_nettype none

module fletcherChecker
    import fletcherPkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     wordValid,
    input  wire word_t    wordData,
    input  wire logic     wordLast,
    output logic          csumValid,
    output csum_t         csum,
    output logic          csumMatch,
    input  wire logic     regWrite,
    input  wire logic     regRead,
    input  wire regAddr_t regAddr,
    input  wire regData_t regWriteData,
    output regData_t      regReadData,
    output logic          regReadValid
);

    csumResultIf res ();
    csumStatusIf status ();

    fletcherEngine engine (
        .clk       (clk),
        .rst       (rst),
        .wordValid (wordValid),
        .wordData  (wordData),
        .wordLast  (wordLast),
        .res       (res.engine)
    );

    // Compares each result against the expected value from the registers
    frameCheck check (
        .clk       (clk),
        .rst       (rst),
        .res       (res.check),
        .status    (status.check),
        .csumValid (csumValid),
        .csum      (csum),
        .csumMatch (csumMatch)
    );

    csumRegs regs (
        .clk          (clk),
        .rst          (rst),
        .regWrite     (regWrite),
        .regRead      (regRead),
        .regAddr      (regAddr),
        .regWriteData (regWriteData),
        .regReadData  (regReadData),
        .regReadValid (regReadValid),
        .status       (status.regs)
    );

endmodule

`default_nettype wire

/* fletcher_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module fletcherChk (
    input wire logic clk,
    input wire logic rst,
    input wire logic wordValid,
    input wire logic wordLast,
    input wire logic csumValid,
    input wire logic csumMatch,
    input wire logic regRead,
    input wire logic regReadValid
);

    // Result strobe lands exactly two cycles after the last word, and never otherwise
    assert property (@(posedge clk) disable iff (rst)
        csumValid == $past(wordValid && wordLast, 2))
        else $error("csumValid is not two cycles after a last word");

    assert property (@(posedge clk) $past(rst) |-> (!csumValid && !csumMatch))
        else $error("csumValid or csumMatch high in the cycle after reset");

    assert property (@(posedge clk) disable iff (rst)
        regReadValid == $past(regRead))
        else $error("regReadValid does not follow regRead by one cycle");

endmodule

bind fletcherChecker fletcherChk chk (
    .clk          (clk),
    .rst          (rst),
    .wordValid    (wordValid),
    .wordLast     (wordLast),
    .csumValid    (csumValid),
    .csumMatch    (csumMatch),
    .regRead      (regRead),
    .regReadValid (regReadValid)
);

`default_nettype wire

/* tbFletcher.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fletcher_params.svh"

module tbFletcher
    import fletcherPkg::*;
();

    localparam int FILL_POOL = 0;
    localparam int FILL_ONES = 1;
    localparam int FILL_RAND = 2;
    localparam int EXP_MODEL = 0;
    localparam int EXP_BAD = 1;
    localparam int EXP_LIT = 2;
    localparam int NUM_ROWS = 14;
    localparam int FIRST_RANDOM_ROW = 8;
    localparam int WAIT_LIMIT = 200;

    typedef struct packed {
        int    fill;
        int    len;      // Zero picks a random length of 1 to 40
        int    poolIdx;
        bit    b2b;      // Starts right after the previous frame with no idle cycle
        bit    cmpEn;
        int    expSrc;
        csum_t expLit;
        bit    expMatch;
    } frameRow_t;

    typedef struct packed {
        int    id;
        csum_t sum;
        bit    match;
    } expect_t;

    logic      clk;
    logic      rst;
    logic      wordValid;
    word_t     wordData;
    logic      wordLast;
    logic      csumValid;
    csum_t     csum;
    logic      csumMatch;
    logic      regWrite;
    logic      regRead;
    regAddr_t  regAddr;
    regData_t  regWriteData;
    regData_t  regReadData;
    logic      regReadValid;

    frameRow_t rows [NUM_ROWS];
    word_t     pool [6];
    expect_t   expQ [$];
    int        dueQ [$];
    expect_t   doneFrame;
    int        negIdx;
    int        passCount;
    int        failCount;
    csum_t     lastSum;
    frameLen_t lastLen;

    fletcherChecker uut (
        .clk          (clk),
        .rst          (rst),
        .wordValid    (wordValid),
        .wordData     (wordData),
        .wordLast     (wordLast),
        .csumValid    (csumValid),
        .csum         (csum),
        .csumMatch    (csumMatch),
        .regWrite     (regWrite),
        .regRead      (regRead),
        .regAddr      (regAddr),
        .regWriteData (regWriteData),
        .regReadData  (regReadData),
        .regReadValid (regReadValid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic frameRow_t makeRow(input int fill, input int len, input int poolIdx,
                                          input bit b2b, input bit cmpEn, input int expSrc,
                                          input csum_t expLit, input bit expMatch);
        frameRow_t r;
        r.fill = fill;
        r.len = len;
        r.poolIdx = poolIdx;
        r.b2b = b2b;
        r.cmpEn = cmpEn;
        r.expSrc = expSrc;
        r.expLit = expLit;
        r.expMatch = expMatch;
        return r;
    endfunction

    task automatic buildTable();
        pool[0] = 16'h6261; // "abcde" packed little endian, two bytes per word
        pool[1] = 16'h6463;
        pool[2] = 16'h0065;
        pool[3] = 16'h1234;
        pool[4] = 16'hFFFF;
        pool[5] = 16'h0001;
        rows[0] = makeRow(FILL_POOL, 3, 0, 1'b0, 1'b1, EXP_LIT, 32'hF04F_C729, 1'b1);
        rows[1] = makeRow(FILL_ONES, 4, 0, 1'b0, 1'b0, EXP_MODEL, '0, 1'b1);
        rows[2] = makeRow(FILL_POOL, 1, 3, 1'b1, 1'b0, EXP_MODEL, '0, 1'b1);
        rows[3] = makeRow(FILL_RAND, 5, 0, 1'b1, 1'b0, EXP_MODEL, '0, 1'b1);
        rows[4] = makeRow(FILL_RAND, 8, 0, 1'b0, 1'b1, EXP_MODEL, '0, 1'b1);
        rows[5] = makeRow(FILL_RAND, 6, 0, 1'b0, 1'b1, EXP_BAD, '0, 1'b0);
        rows[6] = makeRow(FILL_RAND, 3, 0, 1'b0, 1'b0, EXP_BAD, '0, 1'b1);
        rows[7] = makeRow(FILL_POOL, 2, 4, 1'b0, 1'b1, EXP_MODEL, '0, 1'b1);
        for (int i = FIRST_RANDOM_ROW; i < NUM_ROWS; i++) begin
            rows[i] = makeRow(FILL_RAND, 0, 0, (i % 3) != 2, 1'b0, EXP_MODEL, '0, 1'b1);
        end
        rows[FIRST_RANDOM_ROW].b2b = 1'b0; // First random frame follows a register access
    endtask

    // Both sums are plain residues mod 65535, so all ones never shows up
    function automatic csum_t fletcherModel(input word_t w[$]);
        int unsigned a;
        int unsigned b;
        csum_t       r;
        a = 0;
        b = 0;
        foreach (w[i]) begin
            a = (a + w[i]) % 65535;
            b = (b + a) % 65535;
        end
        r.sumA = halfSum_t'(a);
        r.sumB = halfSum_t'(b);
        return r;
    endfunction

    task automatic checkCsum(input int id, input csum_t got, input logic gotMatch,
                             input csum_t exp, input logic expMatch);
        if (got !== exp || gotMatch !== expMatch) begin
            failCount++;
            $display("[FAIL] time %0t: frame %0d checksum %h match %b, expected %h match %b",
                     $time, id, got, gotMatch, exp, expMatch);
        end else begin
            passCount++;
            $display("[PASS] frame %0d checksum %h match %b", id, got, gotMatch);
        end
    endtask

    task automatic checkReg(input string name, input regData_t got, input regData_t exp);
        if (got !== exp) begin
            failCount++;
            $display("[FAIL] time %0t: %s read %h, expected %h", $time, name, got, exp);
        end else begin
            passCount++;
            $display("[PASS] %s read %h", name, got);
        end
    endtask

    task automatic abortRun(input string why);
        failCount++;
        $display("Run stopped at time %0t: %s", $time, why);
        $display("Checks: %0d passed, %0d failed", passCount, failCount);
        $display("Test failed");
        $finish;
    endtask

    task automatic writeReg(input regAddr_t addr, input regData_t data);
        @(posedge clk);
        regWrite <= 1'b1;
        regAddr <= addr;
        regWriteData <= data;
        @(posedge clk);
        regWrite <= 1'b0;
    endtask

    task automatic verifyReg(input regAddr_t addr, input string name, input regData_t exp);
        int n;
        @(posedge clk);
        regRead <= 1'b1;
        regAddr <= addr;
        @(posedge clk);
        regRead <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!regReadValid && n < WAIT_LIMIT);
        if (!regReadValid) begin
            abortRun($sformatf("register %0d never returned read data", addr));
        end else begin
            checkReg(name, regReadData, exp);
        end
    endtask

    task automatic sendFrame(input word_t w[$]);
        foreach (w[i]) begin
            @(posedge clk);
            wordValid <= 1'b1;
            wordData <= w[i];
            wordLast <= (i == w.size() - 1);
        end
    endtask

    task automatic idleStream();
        @(posedge clk);
        wordValid <= 1'b0;
        wordLast <= 1'b0;
        wordData <= '0;
    endtask

    // Polls on the rising edge, away from the falling edge where results are popped
    task automatic drainResults();
        int n;
        n = 0;
        while (expQ.size() != 0 && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (expQ.size() != 0) begin
            abortRun("frame results stopped arriving");
        end
    endtask

    task automatic applyRow(input int idx);
        frameRow_t r;
        word_t     words [$];
        int        len;
        csum_t     model;
        csum_t     expVal;
        expect_t   e;
        r = rows[idx];
        len = (r.len == 0) ? int'($urandom_range(40, 1)) : r.len;
        for (int i = 0; i < len; i++) begin
            case (r.fill)
                FILL_POOL: words.push_back(pool[r.poolIdx + i]);
                FILL_ONES: words.push_back(16'hFFFF);
                default:   words.push_back(word_t'($urandom()));
            endcase
        end
        model = fletcherModel(words);
        if (r.expSrc == EXP_LIT) begin
            expVal = r.expLit;
        end else if (r.expSrc == EXP_BAD) begin
            expVal = csum_t'(regData_t'(model) ^ 32'h0000_0100); // One flipped bit in sumA
        end else begin
            expVal = model;
        end
        if (!r.b2b) begin
            drainResults();
            writeReg(`FL_REG_CTRL, regData_t'(r.cmpEn));
            writeReg(`FL_REG_EXPECT, regData_t'(expVal));
        end
        e.id = idx;
        e.sum = model;
        e.match = r.expMatch;
        expQ.push_back(e);
        sendFrame(words);
        lastSum = model;
        lastLen = frameLen_t'(len);
    endtask

    // A last word seen at one falling edge owes its result two falling edges later
    always @(negedge clk) begin
        if (!rst) begin
            if (wordValid && wordLast) begin
                dueQ.push_back(negIdx + 2);
            end
            if (csumValid) begin
                if (dueQ.size() == 0 || dueQ[0] != negIdx || expQ.size() == 0) begin
                    failCount++;
                    $display("Checksum result at time %0t with no frame due", $time);
                end else begin
                    void'(dueQ.pop_front());
                    doneFrame = expQ.pop_front();
                    checkCsum(doneFrame.id, csum, csumMatch, doneFrame.sum, doneFrame.match);
                end
            end else if (dueQ.size() != 0 && dueQ[0] <= negIdx) begin
                void'(dueQ.pop_front());
                failCount++;
                if (expQ.size() != 0) begin
                    doneFrame = expQ.pop_front();
                end
                $display("Frame %0d gave no result two cycles after its last word", doneFrame.id);
            end
        end
        negIdx++;
    end

    initial begin
        int errorsExpected;
        rst = 1'b1;
        wordValid = 1'b0;
        wordData = '0;
        wordLast = 1'b0;
        regWrite = 1'b0;
        regRead = 1'b0;
        regAddr = '0;
        regWriteData = '0;
        negIdx = 0;
        passCount = 0;
        failCount = 0;
        errorsExpected = 0;
        void'($urandom(32'h5fa0));
        buildTable();
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        verifyReg(`FL_REG_CTRL, "CTRL after reset", '0);
        verifyReg(`FL_REG_EXPECT, "EXPECT after reset", '0);
        for (int i = 0; i < FIRST_RANDOM_ROW; i++) begin
            applyRow(i);
            if (!rows[i + 1].b2b) begin
                idleStream();
            end
            errorsExpected += rows[i].expMatch ? 0 : 1;
        end
        drainResults();
        verifyReg(`FL_REG_FRAMES, "FRAMES", FIRST_RANDOM_ROW);
        verifyReg(`FL_REG_ERRORS, "ERRORS", errorsExpected);
        verifyReg(`FL_REG_LAST, "LAST", regData_t'(lastSum));
        verifyReg(`FL_REG_LEN, "LEN", regData_t'(lastLen));
        writeReg(`FL_REG_CTRL, 32'h2);
        verifyReg(`FL_REG_FRAMES, "FRAMES after clear", '0);
        verifyReg(`FL_REG_ERRORS, "ERRORS after clear", '0);
        for (int i = FIRST_RANDOM_ROW; i < NUM_ROWS; i++) begin
            applyRow(i);
            if (i + 1 == NUM_ROWS || !rows[i + 1].b2b) begin
                idleStream();
            end
        end
        drainResults();
        verifyReg(`FL_REG_FRAMES, "FRAMES after random frames", NUM_ROWS - FIRST_RANDOM_ROW);
        verifyReg(`FL_REG_ERRORS, "ERRORS after random frames", '0);
        $display("Checks: %0d passed, %0d failed", passCount, failCount);
        if (failCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+.
fletcherPkg.sv
fletcherIfs.sv
fletcherEngine.sv
frameCheck.sv
csumRegs.sv
fletcherChecker.sv
fletcher_chk.sv
tbFletcher.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tbFletcher
FILELIST   ?= all.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= -Wall
PASS_TEXT  ?= Test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The exit status comes from the search for the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only --timing --assert $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
